// File: filelist.f
rtl/soc_bus_pkg.sv
rtl/bus_arbiter.sv
rtl/mem_region_decode.sv
rtl/boot_rom.sv
rtl/io_port_regs.sv
rtl/soc_bus_top.sv
verification/soc_bus_tb.sv

// File: rtl/boot_rom.hex
// One 16-bit boot ROM word per line, word index 0 to 15
fa33
31c0
8ed8
8ec0
bc00
7cfb
e80a
00ea
1e00
00f0
1234
5a5a
a5c3
0f1e
7788
c0de

// File: rtl/boot_rom.sv
// Boot ROM preloaded from a hex image, answers each access one cycle later
module boot_rom (
    input  logic               sys_clk,
    input  logic               reset,
    input  logic               access,
    input  soc_bus_pkg::addr_t addr,
    output soc_bus_pkg::word_t rdata,
    output logic               ack
);

    import soc_bus_pkg::*;

    word_t rom [rom_words];

    initial begin
        $readmemh("rtl/boot_rom.hex", rom);
    end

    // Writes are acked like reads and leave the contents alone
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access & ~ack; // Drops after one cycle even if access stays
        end
    end

    always_ff @(posedge sys_clk) begin
        rdata <= rom[addr[rom_index_bits:1]]; // Upper bits alias
    end

endmodule

// File: rtl/bus_arbiter.sv
// Two-master round-robin arbiter that merges two access/ack buses onto one downstream bus
module bus_arbiter (
    input  logic                  sys_clk,
    input  logic                  reset,
    // Master a
    input  soc_bus_pkg::addr_t    a_addr,
    input  soc_bus_pkg::word_t    a_wdata,
    output soc_bus_pkg::word_t    a_rdata,
    input  logic                  a_access,
    input  logic                  a_wr_en,
    input  soc_bus_pkg::bytesel_t a_bytesel,
    output logic                  a_ack,
    // Master b
    input  soc_bus_pkg::addr_t    b_addr,
    input  soc_bus_pkg::word_t    b_wdata,
    output soc_bus_pkg::word_t    b_rdata,
    input  logic                  b_access,
    input  logic                  b_wr_en,
    input  soc_bus_pkg::bytesel_t b_bytesel,
    output logic                  b_ack,
    // Downstream bus
    output soc_bus_pkg::addr_t    q_addr,
    output soc_bus_pkg::word_t    q_wdata,
    input  soc_bus_pkg::word_t    q_rdata,
    output logic                  q_access,
    output logic                  q_wr_en,
    output soc_bus_pkg::bytesel_t q_bytesel,
    input  logic                  q_ack
);

    logic grant_a;
    logic grant_b;
    logic last_b; // Set when b won the previous arbitration
    logic busy;

    assign busy = grant_a | grant_b;

    // One transaction in flight, grant held until the downstream ack
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            grant_a <= 1'b0;
            grant_b <= 1'b0;
            last_b  <= 1'b1; // So a wins the first tie
        end else if (busy) begin
            if (q_ack) begin
                grant_a <= 1'b0;
                grant_b <= 1'b0;
            end
        end else if (a_access && (!b_access || last_b)) begin
            grant_a <= 1'b1;
            last_b  <= 1'b0;
        end else if (b_access) begin
            grant_b <= 1'b1;
            last_b  <= 1'b1;
        end
    end

    // Request fields follow the grant
    assign q_access  = busy;
    assign q_addr    = grant_b ? b_addr : a_addr;
    assign q_wdata   = grant_b ? b_wdata : a_wdata;
    assign q_wr_en   = grant_b ? b_wr_en : a_wr_en;
    assign q_bytesel = grant_b ? b_bytesel : a_bytesel;

    // Ack goes back in the same cycle, data is shared
    assign a_ack   = grant_a & q_ack;
    assign b_ack   = grant_b & q_ack;
    assign a_rdata = q_rdata;
    assign b_rdata = q_rdata;

    ack_exclusive: assert property (@(posedge sys_clk) disable iff (reset)
        !(a_ack && b_ack));

    // A downstream slave may stall but never sees the access withdrawn
    access_held: assert property (@(posedge sys_clk) disable iff (reset)
        q_access && !q_ack |=> q_access);

endmodule

// File: rtl/io_port_regs.sv
// I/O port block with the LED, boot-enable and SDRAM status ports plus a default port
module io_port_regs (
    input  logic                          sys_clk,
    input  logic                          reset,
    input  logic                          access,
    input  logic                          wr_en,
    input  soc_bus_pkg::addr_t            addr,
    input  soc_bus_pkg::word_t            wdata,
    input  soc_bus_pkg::bytesel_t         bytesel,
    output soc_bus_pkg::word_t            rdata,
    output logic                          ack,
    input  logic                          sdram_config_done,
    output logic                          bios_enabled,
    output logic [soc_bus_pkg::num_leds-1:0] leds
);

    import soc_bus_pkg::*;

    logic [15:0] port;
    logic        leds_sel;
    logic        status_sel;
    logic        bios_sel;
    logic        start;     // First cycle of an access
    word_t       rdata_next;

    // I/O space is 16 bits wide, byte bit 0 is not on the bus
    assign port       = {addr[15:1], 1'b0};
    assign leds_sel   = (port == port_leds);
    assign status_sel = (port == port_sdram_status);
    assign bios_sel   = (port == port_bios_control);

    assign start = access & ~ack;

    // Undecoded ports fall through to zero
    always_comb begin
        rdata_next = '0;
        if (leds_sel) begin
            rdata_next = word_t'(leds);
        end else if (bios_sel) begin
            rdata_next = word_t'(bios_enabled);
        end else if (status_sel) begin
            rdata_next = word_t'(sdram_config_done);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= start; // Every port, decoded or not, answers
        end
    end

    // Read value is sampled before any write on the same edge
    always_ff @(posedge sys_clk) begin
        if (start) begin
            rdata <= rdata_next;
        end
    end

    // Register writes land on the edge that raises ack
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            leds         <= '0;
            bios_enabled <= bios_enable_reset;
        end else if (start && wr_en && bytesel[0]) begin
            // Both registers live in the low byte lane
            if (leds_sel) begin
                leds <= wdata[num_leds-1:0];
            end
            if (bios_sel) begin
                bios_enabled <= wdata[0];
            end
        end
    end

    port_select_onehot: assert property (@(posedge sys_clk) disable iff (reset)
        $onehot0({leds_sel, status_sel, bios_sel}));

endmodule

// File: rtl/mem_region_decode.sv
// Address decoder that steers the merged memory bus to the boot ROM or the SDRAM port
module mem_region_decode (
    // Merged memory bus from the arbiters
    input  soc_bus_pkg::addr_t    m_addr,
    input  soc_bus_pkg::word_t    m_wdata,
    output soc_bus_pkg::word_t    m_rdata,
    input  logic                  m_access,
    input  logic                  m_wr_en,
    input  soc_bus_pkg::bytesel_t m_bytesel,
    output logic                  m_ack,
    // Boot region mapping from the I/O ports
    input  logic                  bios_enabled,
    // Boot ROM
    output logic                  rom_access,
    input  soc_bus_pkg::word_t    rom_rdata,
    input  logic                  rom_ack,
    // External SDRAM port
    output soc_bus_pkg::addr_t    sdram_addr,
    output soc_bus_pkg::word_t    sdram_wdata,
    input  soc_bus_pkg::word_t    sdram_rdata,
    output logic                  sdram_access,
    output logic                  sdram_wr_en,
    output soc_bus_pkg::bytesel_t sdram_bytesel,
    input  logic                  sdram_ack
);

    import soc_bus_pkg::*;

    logic rom_sel;

    // Boot region only while the ROM is mapped in
    assign rom_sel = bios_enabled && (m_addr[19:14] == bios_prefix);

    always_comb begin
        rom_access   = m_access & rom_sel;
        sdram_access = m_access & ~rom_sel;

        // Return path follows the selected slave
        if (rom_sel) begin
            m_rdata = rom_rdata;
            m_ack   = rom_ack;
        end else begin
            m_rdata = sdram_rdata;
            m_ack   = sdram_ack;
        end

        assert (!(rom_access && sdram_access));
    end

    // Payload goes straight out, access alone marks the target
    assign sdram_addr    = m_addr;
    assign sdram_wdata   = m_wdata;
    assign sdram_wr_en   = m_wr_en;
    assign sdram_bytesel = m_bytesel;

endmodule

// File: rtl/soc_bus_pkg.sv
// Shared bus types, port addresses and sizes, imported by every fabric module
package soc_bus_pkg;

    // Bus payload types
    typedef logic [15:0] word_t;    // One 16-bit data word
    typedef logic [19:1] addr_t;    // Word address, byte bit 0 dropped
    typedef logic [1:0]  bytesel_t; // Bit 0 is the low byte lane

    // LED pins on the board
    localparam int num_leds = 8;

    // Boot ROM geometry
    localparam int rom_words = 16;
    localparam int rom_index_bits = $clog2(rom_words);

    // Top address bits of the boot region, 0xFC000 to 0xFFFFF
    localparam logic [5:0] bios_prefix = 6'b11_1111;

    // I/O byte addresses decoded by the port block
    localparam logic [15:0] port_leds         = 16'hfffe;
    localparam logic [15:0] port_sdram_status = 16'hfffc;
    localparam logic [15:0] port_bios_control = 16'hffec;

    // The ROM is mapped in out of reset so the CPU can boot from it
    localparam logic bios_enable_reset = 1'b1;

endpackage

// File: rtl/soc_bus_top.sv
// Bus fabric top level joining the CPU and FPU buses to the boot ROM, SDRAM port and I/O ports
module soc_bus_top (
    input  logic                          sys_clk,
    input  logic                          reset,
    // CPU instruction bus, read only
    input  soc_bus_pkg::addr_t            instr_addr,
    input  logic                          instr_access,
    output logic                          instr_ack,
    output soc_bus_pkg::word_t            instr_rdata,
    // CPU data bus
    input  soc_bus_pkg::addr_t            data_addr,
    input  soc_bus_pkg::word_t            data_wdata,
    output soc_bus_pkg::word_t            data_rdata,
    input  logic                          data_access,
    input  logic                          data_wr_en,
    input  soc_bus_pkg::bytesel_t         data_bytesel,
    input  logic                          data_io,
    output logic                          data_ack,
    // FPU memory bus
    input  soc_bus_pkg::addr_t            fpu_addr,
    input  soc_bus_pkg::word_t            fpu_wdata,
    output soc_bus_pkg::word_t            fpu_rdata,
    input  logic                          fpu_access,
    input  logic                          fpu_wr_en,
    input  soc_bus_pkg::bytesel_t         fpu_bytesel,
    output logic                          fpu_ack,
    // External SDRAM port
    output soc_bus_pkg::addr_t            sdram_addr,
    output soc_bus_pkg::word_t            sdram_wdata,
    input  soc_bus_pkg::word_t            sdram_rdata,
    output logic                          sdram_access,
    output logic                          sdram_wr_en,
    output soc_bus_pkg::bytesel_t         sdram_bytesel,
    input  logic                          sdram_ack,
    input  logic                          sdram_config_done,
    output logic [soc_bus_pkg::num_leds-1:0] leds
);

    import soc_bus_pkg::*;

    // Data bus split by the I/O flag
    logic     data_mem_access;
    logic     data_mem_ack;
    word_t    data_mem_rdata;
    logic     io_access;
    logic     io_ack;
    word_t    io_rdata;

    // Instruction and data merged
    addr_t    cpu_addr;
    word_t    cpu_wdata;
    word_t    cpu_rdata;
    logic     cpu_access;
    logic     cpu_wr_en;
    bytesel_t cpu_bytesel;
    logic     cpu_ack;

    // Final memory bus
    addr_t    mem_addr;
    word_t    mem_wdata;
    word_t    mem_rdata;
    logic     mem_access;
    logic     mem_wr_en;
    bytesel_t mem_bytesel;
    logic     mem_ack;

    logic     rom_access;
    word_t    rom_rdata;
    logic     rom_ack;
    logic     bios_enabled;

    assign data_mem_access = data_access & ~data_io;
    assign io_access       = data_access & data_io;

    // Only one of the two paths can answer a given access
    assign data_ack   = data_mem_ack | io_ack;
    assign data_rdata = data_io ? io_rdata : data_mem_rdata;

    bus_arbiter cpu_arbiter (
        .sys_clk(sys_clk), .reset(reset),
        .a_addr(instr_addr), .a_wdata('0), .a_rdata(instr_rdata),
        .a_access(instr_access), .a_wr_en(1'b0), .a_bytesel(2'b11), .a_ack(instr_ack),
        .b_addr(data_addr), .b_wdata(data_wdata), .b_rdata(data_mem_rdata),
        .b_access(data_mem_access), .b_wr_en(data_wr_en), .b_bytesel(data_bytesel),
        .b_ack(data_mem_ack),
        .q_addr(cpu_addr), .q_wdata(cpu_wdata), .q_rdata(cpu_rdata),
        .q_access(cpu_access), .q_wr_en(cpu_wr_en), .q_bytesel(cpu_bytesel),
        .q_ack(cpu_ack)
    );

    bus_arbiter fpu_arbiter (
        .sys_clk(sys_clk), .reset(reset),
        .a_addr(cpu_addr), .a_wdata(cpu_wdata), .a_rdata(cpu_rdata),
        .a_access(cpu_access), .a_wr_en(cpu_wr_en), .a_bytesel(cpu_bytesel), .a_ack(cpu_ack),
        .b_addr(fpu_addr), .b_wdata(fpu_wdata), .b_rdata(fpu_rdata),
        .b_access(fpu_access), .b_wr_en(fpu_wr_en), .b_bytesel(fpu_bytesel), .b_ack(fpu_ack),
        .q_addr(mem_addr), .q_wdata(mem_wdata), .q_rdata(mem_rdata),
        .q_access(mem_access), .q_wr_en(mem_wr_en), .q_bytesel(mem_bytesel),
        .q_ack(mem_ack)
    );

    mem_region_decode mem_decode (
        .m_addr(mem_addr), .m_wdata(mem_wdata), .m_rdata(mem_rdata),
        .m_access(mem_access), .m_wr_en(mem_wr_en), .m_bytesel(mem_bytesel), .m_ack(mem_ack),
        .bios_enabled(bios_enabled),
        .rom_access(rom_access), .rom_rdata(rom_rdata), .rom_ack(rom_ack),
        .sdram_addr(sdram_addr), .sdram_wdata(sdram_wdata), .sdram_rdata(sdram_rdata),
        .sdram_access(sdram_access), .sdram_wr_en(sdram_wr_en),
        .sdram_bytesel(sdram_bytesel), .sdram_ack(sdram_ack)
    );

    boot_rom rom (
        .sys_clk(sys_clk), .reset(reset),
        .access(rom_access), .addr(mem_addr),
        .rdata(rom_rdata), .ack(rom_ack)
    );

    io_port_regs io_ports (
        .sys_clk(sys_clk), .reset(reset),
        .access(io_access), .wr_en(data_wr_en), .addr(data_addr),
        .wdata(data_wdata), .bytesel(data_bytesel),
        .rdata(io_rdata), .ack(io_ack),
        .sdram_config_done(sdram_config_done),
        .bios_enabled(bios_enabled), .leds(leds)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module soc_bus_tb -f filelist.f > build.log 2>&1 \
    && ./obj_dir/Vsoc_bus_tb > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "tests failed" sim.log \
    && { echo "Simulation reported failures, see sim.log"; exit 1; } \
    || echo "Simulation finished without failures"
exit 0

// File: verification/soc_bus_tb.sv
// Directed testbench for the bus fabric with an SDRAM model, run from the project root
module soc_bus_tb;

    import soc_bus_pkg::*;

    localparam int          sdram_index_bits = 12;
    localparam int          sdram_words = 1 << sdram_index_bits;
    localparam logic [31:0] rng_seed = 32'hf25b;
    localparam int          ack_timeout = 64; // Cycles a master waits for its ack

    logic     sys_clk;
    logic     reset;
    addr_t    instr_addr;
    logic     instr_access;
    logic     instr_ack;
    word_t    instr_rdata;
    addr_t    data_addr;
    word_t    data_wdata;
    word_t    data_rdata;
    logic     data_access;
    logic     data_wr_en;
    bytesel_t data_bytesel;
    logic     data_io;
    logic     data_ack;
    addr_t    fpu_addr;
    word_t    fpu_wdata;
    word_t    fpu_rdata;
    logic     fpu_access;
    logic     fpu_wr_en;
    bytesel_t fpu_bytesel;
    logic     fpu_ack;
    addr_t    sdram_addr;
    word_t    sdram_wdata;
    word_t    sdram_rdata = '0;
    logic     sdram_access;
    logic     sdram_wr_en;
    bytesel_t sdram_bytesel;
    logic     sdram_ack = 1'b0;
    logic     sdram_config_done;
    logic [num_leds-1:0] leds;

    word_t       rom_image [rom_words]; // Expected instruction words
    word_t       sdram_mem [sdram_words];
    logic [31:0] rng_state = rng_seed;
    int          sdram_wait;
    int          sdram_served;          // Completed SDRAM transactions

    int error_count;
    int tests_passed;
    int tests_failed;
    int instr_acks;
    int data_acks;
    int fpu_acks;
    logic [num_leds-1:0] leds_expected;

    soc_bus_top UUT (
        .sys_clk(sys_clk), .reset(reset),
        .instr_addr(instr_addr), .instr_access(instr_access),
        .instr_ack(instr_ack), .instr_rdata(instr_rdata),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_rdata(data_rdata),
        .data_access(data_access), .data_wr_en(data_wr_en), .data_bytesel(data_bytesel),
        .data_io(data_io), .data_ack(data_ack),
        .fpu_addr(fpu_addr), .fpu_wdata(fpu_wdata), .fpu_rdata(fpu_rdata),
        .fpu_access(fpu_access), .fpu_wr_en(fpu_wr_en), .fpu_bytesel(fpu_bytesel),
        .fpu_ack(fpu_ack),
        .sdram_addr(sdram_addr), .sdram_wdata(sdram_wdata), .sdram_rdata(sdram_rdata),
        .sdram_access(sdram_access), .sdram_wr_en(sdram_wr_en),
        .sdram_bytesel(sdram_bytesel), .sdram_ack(sdram_ack),
        .sdram_config_done(sdram_config_done), .leds(leds)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Distinct power-up contents for every model word
    function automatic word_t fill_word(input logic [sdram_index_bits-1:0] index);
        return {index[7:0], 4'h9, index[11:8]} ^ 16'h3c5a;
    endfunction

    function automatic logic [sdram_index_bits-1:0] model_index(input addr_t a);
        return a[sdram_index_bits:1]; // Upper bits alias
    endfunction

    function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                          input bytesel_t sel);
        word_t merged;
        merged = old_word;
        if (sel[0]) begin
            merged[7:0] = new_word[7:0];
        end
        if (sel[1]) begin
            merged[15:8] = new_word[15:8];
        end
        return merged;
    endfunction

    function automatic addr_t io_addr(input logic [15:0] port);
        return {4'h0, port[15:1]};
    endfunction

    function automatic addr_t mem_addr(input logic [19:0] byte_addr);
        return byte_addr[19:1];
    endfunction

    initial begin
        $readmemh("rtl/boot_rom.hex", rom_image);
        for (int i = 0; i < sdram_words; i++) begin
            sdram_mem[i] = fill_word(sdram_index_bits'(i));
        end
    end

    // SDRAM model, answers 1 to 4 cycles after it sees access
    always @(posedge sys_clk) begin
        sdram_ack <= 1'b0;
        if (reset) begin
            sdram_wait = 0;
        end else if (sdram_access && !sdram_ack) begin
            if (sdram_wait == 0) begin
                rng_state = xorshift32(rng_state);
                sdram_wait = int'(rng_state[1:0]) + 1;
            end
            sdram_wait = sdram_wait - 1;
            if (sdram_wait == 0) begin
                sdram_ack    <= 1'b1;
                sdram_served <= sdram_served + 1;
                if (sdram_wr_en) begin
                    sdram_mem[model_index(sdram_addr)] <=
                        merge_lanes(sdram_mem[model_index(sdram_addr)], sdram_wdata,
                                    sdram_bytesel);
                end else begin
                    sdram_rdata <= sdram_mem[model_index(sdram_addr)];
                end
            end
        end
    end

    // Ack pulses per master
    always @(negedge sys_clk) begin
        if (!reset) begin
            instr_acks <= instr_acks + int'(instr_ack);
            data_acks  <= data_acks + int'(data_ack);
            fpu_acks   <= fpu_acks + int'(fpu_ack);
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic check_leds(input string what, input logic [num_leds-1:0] got,
                              input logic [num_leds-1:0] expected);
        if (got !== expected) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic do_instr_read(input addr_t addr, output word_t rdata, output int cycles);
        @(posedge sys_clk);
        instr_addr   <= addr;
        instr_access <= 1'b1;
        cycles = 0;
        @(negedge sys_clk);
        while (!instr_ack && cycles < ack_timeout) begin
            cycles++;
            @(negedge sys_clk);
        end
        if (!instr_ack) begin
            $display("Timeout: instruction read at %h was never acknowledged", addr);
            error_count++;
        end
        rdata = instr_rdata;
        @(posedge sys_clk);
        instr_access <= 1'b0;
    endtask

    task automatic do_data_access(input addr_t addr, input logic io, input logic wr,
                                  input word_t wdata, input bytesel_t sel,
                                  output word_t rdata, output int cycles);
        @(posedge sys_clk);
        data_addr    <= addr;
        data_io      <= io;
        data_wr_en   <= wr;
        data_wdata   <= wdata;
        data_bytesel <= sel;
        data_access  <= 1'b1;
        cycles = 0;
        @(negedge sys_clk);
        while (!data_ack && cycles < ack_timeout) begin
            cycles++;
            @(negedge sys_clk);
        end
        if (!data_ack) begin
            $display("Timeout: data bus access at %h was never acknowledged", addr);
            error_count++;
        end
        rdata = data_rdata;
        @(posedge sys_clk);
        data_access <= 1'b0;
    endtask

    task automatic do_fpu_access(input addr_t addr, input logic wr, input word_t wdata,
                                 input bytesel_t sel, output word_t rdata, output int cycles);
        @(posedge sys_clk);
        fpu_addr    <= addr;
        fpu_wr_en   <= wr;
        fpu_wdata   <= wdata;
        fpu_bytesel <= sel;
        fpu_access  <= 1'b1;
        cycles = 0;
        @(negedge sys_clk);
        while (!fpu_ack && cycles < ack_timeout) begin
            cycles++;
            @(negedge sys_clk);
        end
        if (!fpu_ack) begin
            $display("Timeout: FPU access at %h was never acknowledged", addr);
            error_count++;
        end
        rdata = fpu_rdata;
        @(posedge sys_clk);
        fpu_access <= 1'b0;
    endtask

    // One LED port write, then the pins and the readback
    task automatic write_leds_and_verify(input word_t wdata, input bytesel_t sel);
        word_t rdata;
        int    cycles;
        do_data_access(io_addr(port_leds), 1'b1, 1'b1, wdata, sel, rdata, cycles);
        if (sel[0]) begin
            leds_expected = wdata[num_leds-1:0]; // Only the low lane is wired
        end
        check_leds("leds pins", leds, leds_expected);
        check_word("leds write latency", word_t'(cycles), 16'd1);
        do_data_access(io_addr(port_leds), 1'b1, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("leds readback", rdata, word_t'(leds_expected));
    endtask

    task automatic after_reset();
        word_t rdata;
        int    cycles;
        int    errors_before;
        errors_before = error_count;
        leds_expected = '0;
        @(negedge sys_clk);
        check_leds("leds after reset", leds, leds_expected);
        check_word("sdram_access after reset", word_t'(sdram_access), 16'd0);
        check_word("acks after reset", word_t'({instr_ack, data_ack, fpu_ack}), 16'd0);
        do_data_access(io_addr(port_bios_control), 1'b1, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("boot enable after reset", rdata, 16'h0001);
        report_test("after_reset", errors_before);
    endtask

    task automatic led_lanes();
        int errors_before;
        errors_before = error_count;
        write_leds_and_verify(16'ha5c3, 2'b01);
        write_leds_and_verify(16'h7e18, 2'b10); // High lane only, pins keep their value
        write_leds_and_verify(16'h3c96, 2'b11);
        write_leds_and_verify(16'hffff, 2'b00);
        report_test("led_lanes", errors_before);
    endtask

    task automatic status_and_default_ports();
        word_t rdata;
        int    cycles;
        int    errors_before;
        errors_before = error_count;
        @(posedge sys_clk);
        sdram_config_done <= 1'b1;
        do_data_access(io_addr(port_sdram_status), 1'b1, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("status with SDRAM ready", rdata, 16'h0001);
        check_word("status latency", word_t'(cycles), 16'd1);
        @(posedge sys_clk);
        sdram_config_done <= 1'b0;
        do_data_access(io_addr(port_sdram_status), 1'b1, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("status with SDRAM not ready", rdata, 16'h0000);
        do_data_access(io_addr(16'h0060), 1'b1, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("undecoded port read", rdata, 16'h0000);
        check_word("undecoded read latency", word_t'(cycles), 16'd1);
        do_data_access(io_addr(16'h0080), 1'b1, 1'b1, 16'hffff, 2'b11, rdata, cycles);
        check_word("undecoded write latency", word_t'(cycles), 16'd1);
        check_leds("leds after undecoded write", leds, leds_expected);
        report_test("status_and_default_ports", errors_before);
    endtask

    task automatic boot_region_switch();
        addr_t boot;
        word_t rdata;
        int    cycles;
        int    served_before;
        int    errors_before;
        errors_before = error_count;
        boot = mem_addr(20'hffff6);
        served_before = sdram_served;
        do_instr_read(boot, rdata, cycles);
        check_word("boot ROM word", rdata, rom_image[boot[rom_index_bits:1]]);
        check_word("SDRAM use for a ROM read", word_t'(sdram_served - served_before), 16'd0);
        do_data_access(io_addr(port_bios_control), 1'b1, 1'b1, 16'h0000, 2'b01, rdata, cycles);
        do_data_access(io_addr(port_bios_control), 1'b1, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("boot enable cleared", rdata, 16'h0000);
        do_instr_read(boot, rdata, cycles);
        check_word("boot address from SDRAM", rdata, fill_word(model_index(boot)));
        check_word("SDRAM use with ROM off", word_t'(sdram_served - served_before), 16'd1);
        // Map the ROM back in for the later tests
        do_data_access(io_addr(port_bios_control), 1'b1, 1'b1, 16'h0001, 2'b01, rdata, cycles);
        report_test("boot_region_switch", errors_before);
    endtask

    task automatic sdram_byte_lanes();
        addr_t a;
        addr_t b;
        word_t expect_a;
        word_t expect_b;
        word_t rdata;
        int    cycles;
        int    errors_before;
        errors_before = error_count;
        a = mem_addr(20'h01230);
        b = mem_addr(20'h04566);
        expect_a = fill_word(model_index(a));
        do_fpu_access(a, 1'b1, 16'hbeef, 2'b01, rdata, cycles);
        expect_a = {expect_a[15:8], 8'hef};
        do_fpu_access(a, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("FPU low lane write", rdata, expect_a);
        do_data_access(a, 1'b0, 1'b1, 16'h1234, 2'b10, rdata, cycles);
        expect_a = {8'h12, expect_a[7:0]};
        do_data_access(a, 1'b0, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("data high lane write", rdata, expect_a);
        do_data_access(b, 1'b0, 1'b1, 16'hc001, 2'b11, rdata, cycles);
        do_fpu_access(b, 1'b1, 16'h5aa5, 2'b10, rdata, cycles);
        expect_b = 16'h5a01;
        do_fpu_access(b, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("FPU read of merged word", rdata, expect_b);
        do_data_access(b, 1'b0, 1'b0, '0, 2'b11, rdata, cycles);
        check_word("data read of merged word", rdata, expect_b);
        report_test("sdram_byte_lanes", errors_before);
    endtask

    task automatic simultaneous_masters();
        addr_t rom_word;
        addr_t c;
        addr_t d;
        word_t instr_word;
        word_t data_word;
        word_t fpu_word;
        int    instr_cycles;
        int    data_cycles;
        int    fpu_cycles;
        int    acks_before [3];
        int    errors_before;
        errors_before = error_count;
        rom_word = mem_addr(20'hfc00e);
        c = mem_addr(20'h08a02);
        d = mem_addr(20'h00400);
        acks_before = '{instr_acks, data_acks, fpu_acks};
        fork
            do_instr_read(rom_word, instr_word, instr_cycles);
            do_data_access(d, 1'b0, 1'b1, 16'h6b2d, 2'b11, data_word, data_cycles);
            do_fpu_access(c, 1'b0, '0, 2'b11, fpu_word, fpu_cycles);
        join
        repeat (4) @(negedge sys_clk); // Room for a stray second ack to show
        check_word("instruction word", instr_word, rom_image[rom_word[rom_index_bits:1]]);
        check_word("FPU word", fpu_word, fill_word(model_index(c)));
        check_word("instruction acks", word_t'(instr_acks - acks_before[0]), 16'd1);
        check_word("data acks", word_t'(data_acks - acks_before[1]), 16'd1);
        check_word("FPU acks", word_t'(fpu_acks - acks_before[2]), 16'd1);
        do_fpu_access(d, 1'b0, '0, 2'b11, fpu_word, fpu_cycles);
        check_word("word written during contention", fpu_word, 16'h6b2d);
        report_test("simultaneous_masters", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        instr_addr = '0;
        instr_access = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_access = 1'b0;
        data_wr_en = 1'b0;
        data_bytesel = 2'b00;
        data_io = 1'b0;
        fpu_addr = '0;
        fpu_wdata = '0;
        fpu_access = 1'b0;
        fpu_wr_en = 1'b0;
        fpu_bytesel = 2'b00;
        sdram_config_done = 1'b0;
        repeat (16) @(posedge sys_clk);
        reset <= 1'b0;
        after_reset();
        led_lanes();
        status_and_default_ports();
        boot_region_switch();
        sdram_byte_lanes();
        simultaneous_masters();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
